// ==== source/lsu_pkg.sv ====
// shared types, opcodes and address windows, imported by every load/store unit module
`default_nettype none

package lsu_pkg;

	localparam int data_w = 32;
	localparam int addr_w = 32;

	localparam logic [1:0] resp_okay = 2'b00;

	// narrow devices return and take data in the lane of the byte address
	localparam logic [addr_w-1:0] narrow_lo0 = 32'h0f00_0000; // sram
	localparam logic [addr_w-1:0] narrow_hi0 = 32'h0f00_1fff;
	localparam logic [addr_w-1:0] narrow_lo1 = 32'h8000_0000; // psram
	localparam logic [addr_w-1:0] narrow_hi1 = 32'h80ff_ffff;

	typedef enum logic [2:0] {
		ld_none = 3'd0,
		ld_lb   = 3'd1,
		ld_lh   = 3'd2,
		ld_lw   = 3'd3,
		ld_lbu  = 3'd4,
		ld_lhu  = 3'd5
	} load_kind_e;

	typedef enum logic [1:0] {
		st_none = 2'd0,
		st_sb   = 2'd1,
		st_sh   = 2'd2,
		st_sw   = 2'd3
	} store_kind_e;

	// axi size field, log2 of the byte count
	typedef enum logic [2:0] {
		size_1 = 3'd0,
		size_2 = 3'd1,
		size_4 = 3'd2
	} axi_size_e;

	typedef struct packed {
		logic [addr_w-1:0] addr;  // alu result
		logic [data_w-1:0] wdata; // store data, right-justified
		load_kind_e        ld;
		store_kind_e       st;
		logic [4:0]        rd;
		logic              wen;
	} lsu_req_t;

	typedef struct packed {
		logic [4:0]        rd;
		logic              wen;
		logic [data_w-1:0] data;
		logic              err;   // bus returned a nonzero response
	} lsu_wb_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		axi_size_e         size;
	} axi_ar_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		axi_size_e         size;
	} axi_aw_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [3:0]        strb;
	} axi_w_t;

	// true when the address falls in one of the lane-shifted windows
	function automatic logic in_narrow(input logic [addr_w-1:0] addr);
		return ((addr >= narrow_lo0) && (addr <= narrow_hi0)) ||
			((addr >= narrow_lo1) && (addr <= narrow_hi1));
	endfunction

endpackage

`default_nettype wire

// ==== source/lsu_ctrl.sv ====
// request latch and access sequencer of the load/store unit, drives every bus handshake
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
	input  wire                      clock,
	input  wire                      rstn,
	input  wire                      exu_valid_i,
	input  wire lsu_pkg::lsu_req_t   req_i,
	output logic                     lsu_ready_o,
	input  wire                      ar_ready_i,
	input  wire                      aw_ready_i,
	input  wire                      w_ready_i,
	input  wire                      r_valid_i,
	input  wire [1:0]                r_resp_i,
	input  wire                      b_valid_i,
	input  wire [1:0]                b_resp_i,
	input  wire [lsu_pkg::data_w-1:0] load_data_i,
	input  wire                      wbu_ready_i,
	output lsu_pkg::lsu_req_t        req_o,
	output logic                     ar_valid_o,
	output logic                     aw_valid_o,
	output logic                     w_valid_o,
	output logic                     r_ready_o,
	output logic                     b_ready_o,
	output logic                     lsu_valid_o,
	output lsu_pkg::lsu_wb_t         wb_o
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_issue, // address phase outstanding
		s_resp,  // waiting for read data or write response
		s_hold   // record offered to writeback
	} state_e;

	state_e   state_q;
	state_e   state_d;
	lsu_req_t req_q;
	lsu_wb_t  wb_q;
	logic     aw_done_q;
	logic     w_done_q;
	logic     is_load;
	logic     is_store;
	logic     accept;
	logic     ar_fire;
	logic     aw_fire;
	logic     w_fire;
	logic     r_fire;
	logic     b_fire;
	logic     aw_ok;
	logic     w_ok;

	assign is_load  = (req_q.ld != ld_none);
	assign is_store = (req_q.st != st_none) && !is_load; // load wins if both set

	assign lsu_ready_o = (state_q == s_idle);
	assign lsu_valid_o = (state_q == s_hold);
	assign ar_valid_o  = (state_q == s_issue) && is_load;
	assign aw_valid_o  = (state_q == s_issue) && is_store && !aw_done_q;
	assign w_valid_o   = (state_q == s_issue) && is_store && !w_done_q;
	assign r_ready_o   = (state_q == s_resp) && is_load;
	assign b_ready_o   = (state_q == s_resp) && is_store;

	assign accept  = exu_valid_i && lsu_ready_o;
	assign ar_fire = ar_valid_o && ar_ready_i;
	assign aw_fire = aw_valid_o && aw_ready_i;
	assign w_fire  = w_valid_o && w_ready_i;
	assign r_fire  = r_valid_i && r_ready_o;
	assign b_fire  = b_valid_i && b_ready_o;
	assign aw_ok   = aw_done_q || aw_fire;
	assign w_ok    = w_done_q || w_fire;

	always_comb begin
		state_d = state_q;
		case (state_q)
			s_idle: if (accept) state_d = s_issue;
			s_issue: begin
				if (is_load) begin
					if (ar_fire) state_d = s_resp;
				end else if (is_store) begin
					if (aw_ok && w_ok) state_d = s_resp; // both halves of the write in
				end else begin
					state_d = s_hold; // no bus access
				end
			end
			s_resp: if (r_fire || b_fire) state_d = s_hold;
			s_hold: if (wbu_ready_i) state_d = s_idle;
			default: state_d = s_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q   <= s_idle;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			state_q   <= state_d;
			aw_done_q <= (state_q == s_issue) && aw_ok;
			w_done_q  <= (state_q == s_issue) && w_ok;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) req_q <= req_i;
	end

	// record starts as the alu result, a load or a bad response updates it
	always_ff @(posedge clock) begin
		if (accept) begin
			wb_q.rd   <= req_i.rd;
			wb_q.wen  <= req_i.wen;
			wb_q.data <= req_i.addr;
			wb_q.err  <= 1'b0;
		end else if (r_fire) begin
			wb_q.data <= load_data_i;
			wb_q.err  <= (r_resp_i != resp_okay);
		end else if (b_fire) begin
			wb_q.err  <= (b_resp_i != resp_okay);
		end
	end

	assign req_o = req_q;
	assign wb_o  = wb_q;

endmodule

`default_nettype wire

// ==== source/store_align.sv ====
// store datapath, builds byte strobes, lane-shifted write data and the write size
`timescale 1ns/1ps
`default_nettype none

module store_align (
	input  wire lsu_pkg::lsu_req_t req_i,
	output lsu_pkg::axi_w_t        w_o,
	output lsu_pkg::axi_size_e     aw_size_o
);
	import lsu_pkg::*;

	logic [1:0] lane;
	logic [3:0] strb_base;

	// only narrow devices expect the data in the lane of its address
	assign lane = in_narrow(req_i.addr) ? req_i.addr[1:0] : 2'b00;

	always_comb begin
		case (req_i.st)
			st_sb:   strb_base = 4'b0001;
			st_sh:   strb_base = 4'b0011;
			st_sw:   strb_base = 4'b1111;
			default: strb_base = 4'b0000;
		endcase
	end

	always_comb begin
		case (req_i.st)
			st_sb:   aw_size_o = size_1;
			st_sh:   aw_size_o = size_2;
			default: aw_size_o = size_4;
		endcase
	end

	always_comb begin
		w_o.strb = strb_base << lane;
		w_o.data = req_i.wdata << {lane, 3'b000}; // byte steps
	end

endmodule

`default_nettype wire

// ==== source/load_extract.sv ====
// load datapath, selects the addressed byte lanes and sign or zero extends them
`timescale 1ns/1ps
`default_nettype none

module load_extract (
	input  wire lsu_pkg::lsu_req_t     req_i,
	input  wire [lsu_pkg::data_w-1:0]  r_data_i,
	output lsu_pkg::axi_size_e         ar_size_o,
	output logic [lsu_pkg::data_w-1:0] load_data_o
);
	import lsu_pkg::*;

	logic [1:0]        lane;
	logic [data_w-1:0] shifted;

	// other devices already return data right-justified
	assign lane    = in_narrow(req_i.addr) ? req_i.addr[1:0] : 2'b00;
	assign shifted = r_data_i >> {lane, 3'b000};

	always_comb begin
		case (req_i.ld)
			ld_lb:
				load_data_o = {{(data_w - 8){shifted[7]}}, shifted[7:0]};
			ld_lh:
				load_data_o = {{(data_w - 16){shifted[15]}}, shifted[15:0]};
			ld_lbu:
				load_data_o = {{(data_w - 8){1'b0}}, shifted[7:0]};
			ld_lhu:
				load_data_o = {{(data_w - 16){1'b0}}, shifted[15:0]};
			ld_lw:
				load_data_o = shifted;
			default:
				load_data_o = shifted;
		endcase
	end

	always_comb begin
		case (req_i.ld)
			ld_lb, ld_lbu: ar_size_o = size_1;
			ld_lh, ld_lhu: ar_size_o = size_2;
			default:       ar_size_o = size_4;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/lsu_top.sv ====
// load/store unit top, joins the sequencer and both datapaths to the axi-lite ports
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
	input  wire                       clock,
	input  wire                       rstn,
	// execute side
	input  wire                       exu_valid_i,
	output wire                       lsu_ready_o,
	input  wire lsu_pkg::lsu_req_t    req_i,
	// writeback side
	output wire                       lsu_valid_o,
	input  wire                       wbu_ready_i,
	output lsu_pkg::lsu_wb_t          wb_o,
	// read channels
	output lsu_pkg::axi_ar_t          ar_o,
	output wire                       ar_valid_o,
	input  wire                       ar_ready_i,
	input  wire [lsu_pkg::data_w-1:0] r_data_i,
	input  wire [1:0]                 r_resp_i,
	input  wire                       r_valid_i,
	output wire                       r_ready_o,
	// write channels
	output lsu_pkg::axi_aw_t          aw_o,
	output wire                       aw_valid_o,
	input  wire                       aw_ready_i,
	output lsu_pkg::axi_w_t           w_o,
	output wire                       w_valid_o,
	input  wire                       w_ready_i,
	input  wire [1:0]                 b_resp_i,
	input  wire                       b_valid_i,
	output wire                       b_ready_o
);
	import lsu_pkg::*;

	lsu_req_t          req_q;     // request held for the whole access
	axi_size_e         ar_size;
	axi_size_e         aw_size;
	logic [data_w-1:0] load_data;

	lsu_ctrl i_lsu_ctrl (
		.clock       (clock),
		.rstn        (rstn),
		.exu_valid_i (exu_valid_i),
		.req_i       (req_i),
		.lsu_ready_o (lsu_ready_o),
		.ar_ready_i  (ar_ready_i),
		.aw_ready_i  (aw_ready_i),
		.w_ready_i   (w_ready_i),
		.r_valid_i   (r_valid_i),
		.r_resp_i    (r_resp_i),
		.b_valid_i   (b_valid_i),
		.b_resp_i    (b_resp_i),
		.load_data_i (load_data),
		.wbu_ready_i (wbu_ready_i),
		.req_o       (req_q),
		.ar_valid_o  (ar_valid_o),
		.aw_valid_o  (aw_valid_o),
		.w_valid_o   (w_valid_o),
		.r_ready_o   (r_ready_o),
		.b_ready_o   (b_ready_o),
		.lsu_valid_o (lsu_valid_o),
		.wb_o        (wb_o)
	);

	store_align i_store_align (
		.req_i     (req_q),
		.w_o       (w_o),
		.aw_size_o (aw_size)
	);

	load_extract i_load_extract (
		.req_i       (req_q),
		.r_data_i    (r_data_i),
		.ar_size_o   (ar_size),
		.load_data_o (load_data)
	);

	assign ar_o = '{addr: req_q.addr, size: ar_size};
	assign aw_o = '{addr: req_q.addr, size: aw_size};

endmodule

`default_nettype wire

// ==== sim/lsu_sva.sv ====
// handshake and reset assertions, bound into every lsu_ctrl instance
`timescale 1ns/1ps
`default_nettype none

module lsu_sva (
	input wire clock,
	input wire rstn,
	input wire lsu_ready_o,
	input wire lsu_valid_o,
	input wire wbu_ready_i,
	input wire ar_valid_o,
	input wire ar_ready_i,
	input wire aw_valid_o,
	input wire aw_ready_i,
	input wire w_valid_o,
	input wire w_ready_i,
	input wire r_ready_o,
	input wire b_ready_o
);
	int fail_cnt = 0; // summed into the testbench result

	property held_until_taken(v, r);
		@(posedge clock) disable iff (!rstn) (v && !r) |=> v;
	endproperty

	a_ar_hold: assert property (held_until_taken(ar_valid_o, ar_ready_i)) else begin
		$error("ar_valid_o dropped before its transfer");
		fail_cnt++;
	end

	a_aw_hold: assert property (held_until_taken(aw_valid_o, aw_ready_i)) else begin
		$error("aw_valid_o dropped before its transfer");
		fail_cnt++;
	end

	a_w_hold: assert property (held_until_taken(w_valid_o, w_ready_i)) else begin
		$error("w_valid_o dropped before its transfer");
		fail_cnt++;
	end

	a_wb_hold: assert property (held_until_taken(lsu_valid_o, wbu_ready_i)) else begin
		$error("lsu_valid_o dropped before the writeback transfer");
		fail_cnt++;
	end

	// idle and hold are separate states
	a_ready_valid: assert property (@(posedge clock) disable iff (!rstn)
			!(lsu_ready_o && lsu_valid_o)) else begin
		$error("lsu_ready_o and lsu_valid_o high together");
		fail_cnt++;
	end

	a_reset_quiet: assert property (@(posedge clock) $rose(rstn) |->
			!(ar_valid_o || aw_valid_o || w_valid_o || r_ready_o || b_ready_o ||
			lsu_valid_o)) else begin
		$error("handshake output high in the first cycle after reset");
		fail_cnt++;
	end

endmodule

bind lsu_ctrl lsu_sva i_lsu_sva (
	.clock       (clock),
	.rstn        (rstn),
	.lsu_ready_o (lsu_ready_o),
	.lsu_valid_o (lsu_valid_o),
	.wbu_ready_i (wbu_ready_i),
	.ar_valid_o  (ar_valid_o),
	.ar_ready_i  (ar_ready_i),
	.aw_valid_o  (aw_valid_o),
	.aw_ready_i  (aw_ready_i),
	.w_valid_o   (w_valid_o),
	.w_ready_i   (w_ready_i),
	.r_ready_o   (r_ready_o),
	.b_ready_o   (b_ready_o)
);

`default_nettype wire

// ==== sim/tb_lsu.sv ====
// testbench for the load/store unit, runs execute requests against a delayed axi-lite memory model
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
	import lsu_pkg::*;

	logic        clock = 1'b0;
	logic        rstn;
	logic        exu_valid_i;
	logic        lsu_ready_o;
	lsu_req_t    req_i;
	logic        lsu_valid_o;
	logic        wbu_ready_i;
	lsu_wb_t     wb_o;
	axi_ar_t     ar_o;
	logic        ar_valid_o;
	logic        ar_ready_i = 1'b0;
	logic [31:0] r_data_i = '0;
	logic [1:0]  r_resp_i = '0;
	logic        r_valid_i = 1'b0;
	logic        r_ready_o;
	axi_aw_t     aw_o;
	logic        aw_valid_o;
	logic        aw_ready_i = 1'b0;
	axi_w_t      w_o;
	logic        w_valid_o;
	logic        w_ready_i = 1'b0;
	logic [1:0]  b_resp_i = '0;
	logic        b_valid_i = 1'b0;
	logic        b_ready_o;

	logic [31:0] mem [64];     // contents of the bus slave
	logic [31:0] ref_mem [64]; // contents it should have
	lsu_wb_t     exp_q [$];
	lsu_req_t    cur_req = '0; // request the bus slave is serving
	integer      seed = 32'hd48a;
	logic        use_dly = 1'b0;
	logic        force_err = 1'b0; // slave answers the current access with slverr
	int          checks = 0;
	int          errors = 0;
	int          issued = 0;
	int          done_cnt = 0;

	logic [31:0] bases [3] = '{narrow_lo0, narrow_lo1, 32'h2000_0000};
	load_kind_e  lkinds [5] = '{ld_lb, ld_lh, ld_lw, ld_lbu, ld_lhu};
	store_kind_e skinds [3] = '{st_sb, st_sh, st_sw};

	always #4 clock = ~clock;

	lsu_top i_lsu_top (.*);

	function automatic logic in_window(input logic [31:0] a);
		return (a >= narrow_lo0 && a <= narrow_hi0) || (a >= narrow_lo1 && a <= narrow_hi1);
	endfunction

	function automatic int pick_delay();
		logic [31:0] rnd;
		rnd = $random(seed);
		return use_dly ? int'(rnd[1:0]) : 0;
	endfunction

	// expected writeback record for one request
	function automatic lsu_wb_t expect_wb(input lsu_req_t r, input logic [31:0] word,
			input logic err);
		lsu_wb_t     e;
		logic [31:0] v;
		v = word >> (8 * int'(r.addr[1:0]));
		e.rd   = r.rd;
		e.wen  = r.wen;
		e.err  = err;
		e.data = r.addr;
		case (r.ld)
			ld_lb:   e.data = {{24{v[7]}}, v[7:0]};
			ld_lh:   e.data = {{16{v[15]}}, v[15:0]};
			ld_lw:   e.data = v;
			ld_lbu:  e.data = {24'h0, v[7:0]};
			ld_lhu:  e.data = {16'h0, v[15:0]};
			default: ;
		endcase
		return e;
	endfunction

	// bytes of a store land from the addressed byte upward, the rest of the word stays
	function automatic logic [31:0] merge_store(input logic [31:0] word, input lsu_req_t r);
		int n;
		int off;
		n   = (r.st == st_sb) ? 1 : (r.st == st_sh) ? 2 : 4;
		off = int'(r.addr[1:0]);
		for (int i = 0; i < n; i++)
			if (off + i < 4)
				word[(off + i) * 8 +: 8] = r.wdata[i * 8 +: 8];
		return word;
	endfunction

	// bytes moved by the access, the bus size field is log2 of it
	function automatic logic [2:0] bus_size(input lsu_req_t r);
		int n;
		n = 4;
		if (r.ld == ld_lb || r.ld == ld_lbu || (r.ld == ld_none && r.st == st_sb))
			n = 1;
		else if (r.ld == ld_lh || r.ld == ld_lhu || (r.ld == ld_none && r.st == st_sh))
			n = 2;
		return 3'($clog2(n));
	endfunction

	function automatic lsu_req_t build_req(input logic [31:0] a, input load_kind_e ld,
			input store_kind_e st, input logic [31:0] d);
		lsu_req_t r;
		r.addr  = a;
		r.wdata = d;
		r.ld    = ld;
		r.st    = st;
		r.rd    = a[6:2] ^ 5'd7;
		r.wen   = (st == st_none);
		return r;
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] a);
		if (in_window(a))
			return mem[a[7:2]]; // narrow slave leaves bytes in their lanes
		return mem[a[7:2]] >> (8 * int'(a[1:0]));
	endfunction

	task automatic write_word(input logic [31:0] a, input axi_w_t beat);
		int lane;
		for (int i = 0; i < 4; i++) begin
			lane = in_window(a) ? i : i + int'(a[1:0]);
			if (beat.strb[i] && lane < 4)
				mem[a[7:2]][lane * 8 +: 8] = beat.data[i * 8 +: 8];
		end
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %-14s %s", name, (errors == err_before) ? "ok" : "failed");
	endtask

	// queue the expected record, hand the request over, return once lsu_valid_o is up
	task automatic run_req(input lsu_req_t r, input logic err, output int lat);
		if (r.ld == ld_none && r.st != st_none && !err)
			ref_mem[r.addr[7:2]] = merge_store(ref_mem[r.addr[7:2]], r);
		exp_q.push_back(expect_wb(r, ref_mem[r.addr[7:2]], err));
		issued++;
		@(negedge clock);
		force_err   = err;
		cur_req     = r;
		req_i       = r;
		exu_valid_i = 1'b1;
		do @(posedge clock); while (!lsu_ready_o);
		@(negedge clock);
		exu_valid_i = 1'b0;
		req_i.addr  = ~r.addr; // unit must work from its own copy
		req_i.wdata = ~r.wdata;
		req_i.rd    = ~r.rd;
		lat = 0;
		do begin
			@(posedge clock);
			lat++;
		end while (!lsu_valid_o);
	endtask

	always begin : read_port
		logic [31:0] raddr;
		@(negedge clock);
		if (ar_valid_o) begin
			raddr = ar_o.addr;
			check("ar_o.addr", 64'(ar_o.addr), 64'(cur_req.addr));
			check("ar_o.size", 64'(ar_o.size), 64'(bus_size(cur_req)));
			repeat (pick_delay()) @(negedge clock);
			ar_ready_i = 1'b1;
			@(negedge clock);
			ar_ready_i = 1'b0;
			repeat (pick_delay()) @(negedge clock);
			r_data_i  = read_word(raddr);
			r_resp_i  = force_err ? 2'b10 : 2'b00;
			r_valid_i = 1'b1;
			do @(posedge clock); while (!r_ready_o);
			@(negedge clock);
			r_valid_i = 1'b0;
			r_resp_i  = 2'b00;
		end
	end

	// address and data ready each come after their own delay
	always begin : write_port
		logic [31:0] waddr;
		axi_w_t      wbeat;
		int          aw_wait;
		int          w_wait;
		logic        aw_got;
		logic        w_got;
		@(negedge clock);
		if (aw_valid_o) begin
			waddr   = aw_o.addr;
			wbeat   = w_o;
			check("aw_o.addr", 64'(aw_o.addr), 64'(cur_req.addr));
			check("aw_o.size", 64'(aw_o.size), 64'(bus_size(cur_req)));
			aw_wait = pick_delay();
			w_wait  = pick_delay();
			aw_got  = 1'b0;
			w_got   = 1'b0;
			while (!(aw_got && w_got)) begin
				aw_ready_i = !aw_got && (aw_wait == 0);
				w_ready_i  = !w_got && (w_wait == 0);
				@(negedge clock);
				if (aw_ready_i)
					aw_got = 1'b1;
				else if (aw_wait > 0)
					aw_wait--;
				if (w_ready_i)
					w_got = 1'b1;
				else if (w_wait > 0)
					w_wait--;
			end
			aw_ready_i = 1'b0;
			w_ready_i  = 1'b0;
			if (!force_err)
				write_word(waddr, wbeat);
			repeat (pick_delay()) @(negedge clock);
			b_resp_i  = force_err ? 2'b10 : 2'b00;
			b_valid_i = 1'b1;
			do @(posedge clock); while (!b_ready_o);
			@(negedge clock);
			b_valid_i = 1'b0;
			b_resp_i  = 2'b00;
		end
	end

	always @(posedge clock) begin : compare
		lsu_wb_t exp;
		if (rstn && lsu_valid_o && wbu_ready_i) begin
			done_cnt++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("writeback record arrived with no request outstanding");
			end else begin
				exp = exp_q.pop_front();
				check("wb_o", 64'(wb_o), 64'(exp));
			end
		end
	end

	initial begin : watchdog
		int budget;
		budget = (1 + 3 * 5 * 4 + 3 * 3 * 4 * 2 + 40 + 1 + 3) * 40 + 16; // requests, then reset
		repeat (budget) @(posedge clock);
		$display("timeout, the unit stopped completing requests");
		$display("** FAIL **");
		$finish;
	end

	initial begin : stimulus
		int          lat;
		int          e0;
		int          sel;
		int          sva_fails;
		lsu_req_t    r;
		lsu_wb_t     held;
		logic [31:0] a;
		logic [31:0] rnd;
		rstn        = 1'b0;
		exu_valid_i = 1'b0;
		req_i       = '0;
		wbu_ready_i = 1'b1;
		for (int i = 0; i < 64; i++) begin
			mem[i]     = 32'(i * 4) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;
			ref_mem[i] = mem[i];
		end
		repeat (16) @(negedge clock);
		rstn = 1'b1;

		e0 = errors;
		@(negedge clock);
		check("lsu_ready_o", 64'(lsu_ready_o), 64'd1);
		check("valids", 64'({ar_valid_o, aw_valid_o, w_valid_o, r_ready_o, b_ready_o,
			lsu_valid_o}), 64'd0);
		run_req(build_req(32'h1234_5678, ld_none, st_none, '0), 1'b0, lat);
		check("latency", 64'(lat), 64'd2);
		report_test("reset_alu", e0);

		e0 = errors;
		for (int b = 0; b < 3; b++)
			for (int k = 0; k < 5; k++)
				for (int off = 0; off < 4; off++) begin
					a = bases[b] + 32'((k * 4 + off) * 4 + off);
					run_req(build_req(a, lkinds[k], st_none, '0), 1'b0, lat);
				end
		report_test("loads", e0);

		e0 = errors;
		for (int b = 0; b < 3; b++)
			for (int k = 0; k < 3; k++)
				for (int off = 0; off < 4; off++) begin
					a   = bases[b] + 32'((40 + k * 4 + off) * 4 + off);
					rnd = $random(seed);
					run_req(build_req(a, ld_none, skinds[k], rnd), 1'b0, lat);
					run_req(build_req({a[31:2], 2'b00}, ld_lw, st_none, '0), 1'b0, lat);
				end
		report_test("stores", e0);

		e0 = errors;
		use_dly = 1'b1;
		for (int n = 0; n < 40; n++) begin
			rnd = $random(seed);
			a   = bases[int'(rnd[1:0]) % 3] + {24'h0, rnd[13:8], rnd[15:14]};
			sel = int'(rnd[19:16]) % 9;
			rnd = $random(seed);
			if (sel == 0)
				r = build_req(a, ld_none, st_none, rnd);
			else if (sel < 6)
				r = build_req(a, lkinds[sel - 1], st_none, '0);
			else
				r = build_req(a, ld_none, skinds[sel - 6], rnd);
			run_req(r, 1'b0, lat);
		end
		report_test("random_delay", e0);

		e0 = errors;
		@(negedge clock);
		wbu_ready_i = 1'b0;
		run_req(build_req(bases[0] + 32'h14, ld_lw, st_none, '0), 1'b0, lat);
		@(negedge clock);
		held = wb_o;
		repeat (6) begin
			@(negedge clock);
			check("lsu_valid_o", 64'(lsu_valid_o), 64'd1);
			check("lsu_ready_o", 64'(lsu_ready_o), 64'd0);
			check("wb_o", 64'(wb_o), 64'(held));
		end
		wbu_ready_i = 1'b1;
		report_test("backpressure", e0);

		e0 = errors;
		rnd = $random(seed);
		run_req(build_req(bases[0] + 32'h48, ld_lh, st_none, '0), 1'b1, lat);
		run_req(build_req(bases[2] + 32'h4c, ld_none, st_sw, rnd), 1'b1, lat);
		run_req(build_req(bases[2] + 32'h4c, ld_lw, st_none, '0), 1'b0, lat);
		report_test("error_resp", e0);

		wait (done_cnt == issued);
		repeat (2) @(negedge clock);
		sva_fails = i_lsu_top.i_lsu_ctrl.i_lsu_sva.fail_cnt;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/lsu_pkg.sv
source/lsu_ctrl.sv
source/store_align.sv
source/load_extract.sv
source/lsu_top.sv
sim/lsu_sva.sv
sim/tb_lsu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the load/store unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu \
	-Mdir obj_dir -o tb_lsu_sim -f flist.f

out=$(./obj_dir/tb_lsu_sim +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '\*\* PASS \*\*'; then
	exit 0
fi
exit 1
